// File: hdl/bitmap_playfield.sv
// 4-bpp bitmap playfield: fetches one VRAM word per 4 pixels and shifts out colorbase-XORed indexes
`default_nettype none
`timescale 1ns/1ps

`include "video_gen_defs.svh"

module bitmap_playfield (
    video_timing_if.sink            tif,
    video_cfg_if.sink               cfg,
    output      logic               vram_sel_o,     // read request, data next cycle
    output      video_gen_pkg::addr_t vram_addr_o,
    input  wire video_gen_pkg::word_t vram_data_i,
    output      video_gen_pkg::color_t pf_index_o,  // PF_LATENCY after its h_count
    input  wire logic               reset_i,
    input  wire logic               clk
);
    import video_gen_pkg::*;

    // first request at FETCH_LEAD before the first visible pixel, then every 4 cycles
    localparam int    FETCH_START  = `VG_OFFSCREEN_WIDTH - `VG_FETCH_LEAD;
    localparam hres_t H_FETCH_OPEN = hres_t'(FETCH_START - 1);
    localparam hres_t H_FETCH_LAST = hres_t'(FETCH_START + 4 * (`VG_WORDS_PER_LINE - 1));
    localparam logic [1:0] FETCH_PHASE = 2'(FETCH_START);
    // shift load lands so the first nibble shows PF_LATENCY after its pixel
    localparam logic [1:0] LOAD_PHASE  = 2'(`VG_OFFSCREEN_WIDTH + PF_LATENCY - 1);

    logic  fetch_win;                               // inside the fetch window of this line
    logic  rd_pending;                              // vram data arrives this cycle
    addr_t line_addr;                               // first word of current line
    addr_t word_addr;                               // next word to request
    word_t fetch_word;                              // last word returned
    word_t pix_shift;                               // nibbles of the word on screen

    assign vram_sel_o  = fetch_win & ~cfg.pf_cfg.blank & (tif.h_count[1:0] == FETCH_PHASE);
    assign vram_addr_o = word_addr;
    assign pf_index_o  = color_t'(pix_shift[15:12]) ^ cfg.pf_cfg.colorbase;

    // fetch window and line address
    always_ff @(posedge clk) begin
        if (reset_i) begin
            fetch_win  <= 1'b0;
            rd_pending <= 1'b0;
            line_addr  <= '0;                       // matches start address reset
        end else begin
            rd_pending <= vram_sel_o;

            if (tif.h_count == H_FETCH_OPEN && tif.v_visible) begin
                fetch_win <= 1'b1;
            end else if (tif.h_count == H_FETCH_LAST) begin
                fetch_win <= 1'b0;                  // last word of the line requested
            end

            if (tif.end_of_frame) begin
                line_addr <= cfg.pf_cfg.start_addr;
            end else if (tif.end_of_line) begin
                line_addr <= line_addr + cfg.pf_cfg.line_len;
            end
        end
    end

    // word address within the line
    always_ff @(posedge clk) begin
        if (tif.h_count == H_FETCH_OPEN) begin
            word_addr <= line_addr;
        end else if (vram_sel_o) begin
            word_addr <= word_addr + 1'b1;
        end
    end

    // pixel data path
    always_ff @(posedge clk) begin
        if (rd_pending) begin
            fetch_word <= vram_data_i;
        end
        // next word lands in fetch_word on the same edge, shifter takes the held one
        if (tif.h_count[1:0] == LOAD_PHASE) begin
            pix_shift <= fetch_word;
        end else begin
            pix_shift <= {pix_shift[11:0], 4'h0};   // msb nibble first
        end
    end

    // only visible lines may use the memory
    a_sel_visible: assert property (
        @(posedge clk) disable iff (reset_i) vram_sel_o |-> tif.v_visible
    ) else $error("vram select outside visible lines");

endmodule

`default_nettype wire

// File: hdl/pixel_out.sv
// Video output stage: delays timing to the playfield latency and applies the border window
`default_nettype none
`timescale 1ns/1ps

module pixel_out (
    video_timing_if.sink            tif,
    video_cfg_if.sink               cfg,
    input  wire video_gen_pkg::color_t pf_index_i,
    output      video_gen_pkg::color_t color_index_o,
    output      logic               h_blank_o,
    output      logic               v_blank_o,
    output      logic               hsync_o,
    output      logic               vsync_o,
    output      logic               dv_de_o,
    input  wire logic               reset_i,
    input  wire logic               clk
);
    import video_gen_pkg::*;

    logic [PF_LATENCY-1:0][3:0] lvl_d;              // hsync, vsync, h/v visible
    logic  hs_d, vs_d, hv_d, vv_d;
    logic  de_d;
    hres_t col;                                     // visible column of delayed pixel
    logic  use_border;

    assign {hs_d, vs_d, hv_d, vv_d} = lvl_d[PF_LATENCY-1];
    assign de_d       = hv_d & vv_d;
    assign use_border = cfg.pf_cfg.blank | ~de_d | (col < cfg.vid_left) | (col >= cfg.vid_right);

    always_ff @(posedge clk) begin
        color_index_o <= use_border ? cfg.border_color : pf_index_i;
        if (reset_i) begin
            lvl_d     <= '0;
            col       <= '0;
            hsync_o   <= 1'b0;
            vsync_o   <= 1'b0;
            h_blank_o <= 1'b1;
            v_blank_o <= 1'b1;
            dv_de_o   <= 1'b0;
        end else begin
            lvl_d     <= {lvl_d[PF_LATENCY-2:0], {tif.hsync, tif.vsync, tif.h_visible, tif.v_visible}};
            col       <= de_d ? col + 1'b1 : hres_t'(0);
            hsync_o   <= hs_d;
            vsync_o   <= vs_d;
            h_blank_o <= ~hv_d;
            v_blank_o <= ~vv_d;
            dv_de_o   <= de_d;
        end
    end

    // display enable follows the visible area through the whole delay line
    a_de_aligned: assert property (
        @(posedge clk) disable iff (reset_i)
            dv_de_o |-> $past(tif.h_visible && tif.v_visible, PF_LATENCY + 1)
    ) else $error("display enable not aligned with the visible area");

endmodule

`default_nettype wire

// File: hdl/video_bus_if.sv
// Timing and playfield config bundles passed between the video generator blocks
`default_nettype none
`timescale 1ns/1ps

interface video_timing_if;
    import video_gen_pkg::*;

    hres_t  h_count;
    vres_t  v_count;
    logic   h_visible;
    logic   v_visible;
    logic   end_of_line;                        // last cycle of a line
    logic   end_of_frame;                       // last cycle of a frame
    logic   end_of_visible;                     // last cycle of last visible line
    logic   hsync;
    logic   vsync;

    modport source (
        output h_count, v_count, h_visible, v_visible,
        output end_of_line, end_of_frame, end_of_visible, hsync, vsync
    );
    modport sink (
        input  h_count, v_count, h_visible, v_visible,
        input  end_of_line, end_of_frame, end_of_visible, hsync, vsync
    );
endinterface

interface video_cfg_if;
    import video_gen_pkg::*;

    pf_cfg_t pf_cfg;
    color_t  border_color;
    hres_t   vid_left;                          // first column inside window
    hres_t   vid_right;                         // first column right of window

    modport source (output pf_cfg, border_color, vid_left, vid_right);
    modport sink   (input  pf_cfg, border_color, vid_left, vid_right);
endinterface

`default_nettype wire

// File: hdl/video_gen.sv
// Bitmap video generator top level; connects registers, timing, playfield and output stage
`default_nettype none
`timescale 1ns/1ps

module video_gen (
    input  wire logic                       reg_wr_en_i,
    input  wire video_gen_pkg::reg_num_t    reg_num_i,
    input  wire video_gen_pkg::word_t       reg_data_i,
    output      video_gen_pkg::word_t       reg_data_o,
    output      logic                       video_intr_o,   // end of visible area
    output      logic                       vram_sel_o,
    output      video_gen_pkg::addr_t       vram_addr_o,
    input  wire video_gen_pkg::word_t       vram_data_i,    // valid cycle after select
    output      video_gen_pkg::color_t      color_index_o,
    output      logic                       h_blank_o,
    output      logic                       v_blank_o,
    output      logic                       hsync_o,
    output      logic                       vsync_o,
    output      logic                       dv_de_o,
    input  wire logic                       reset_i,
    input  wire logic                       clk             // pixel clock
);
    import video_gen_pkg::*;

    video_timing_if tif();
    video_cfg_if    cfg();

    color_t pf_index;

    video_reg_file u_reg_file (
        .reg_wr_en_i(reg_wr_en_i), .reg_num_i(reg_num_i),
        .reg_data_i(reg_data_i), .reg_data_o(reg_data_o),
        .video_intr_o(video_intr_o), .tif(tif), .cfg(cfg),
        .reset_i(reset_i), .clk(clk)
    );

    video_timing u_timing (.tif(tif), .reset_i(reset_i), .clk(clk));

    bitmap_playfield u_playfield (
        .tif(tif), .cfg(cfg),
        .vram_sel_o(vram_sel_o), .vram_addr_o(vram_addr_o), .vram_data_i(vram_data_i),
        .pf_index_o(pf_index), .reset_i(reset_i), .clk(clk)
    );

    pixel_out u_pixel_out (
        .tif(tif), .cfg(cfg), .pf_index_i(pf_index),
        .color_index_o(color_index_o), .h_blank_o(h_blank_o), .v_blank_o(v_blank_o),
        .hsync_o(hsync_o), .vsync_o(vsync_o), .dv_de_o(dv_de_o),
        .reset_i(reset_i), .clk(clk)
    );

endmodule

`default_nettype wire

// File: hdl/video_gen_defs.svh
// Timing geometry, register numbers and reset values for the video generator; include where needed
`ifndef VIDEO_GEN_DEFS_SVH
`define VIDEO_GEN_DEFS_SVH

// horizontal geometry in pixel clocks, blank area first
`define VG_VISIBLE_WIDTH    32
`define VG_OFFSCREEN_WIDTH  16                  // holds the hsync pulse
`define VG_TOTAL_WIDTH      48
`define VG_HSYNC_START      4
`define VG_HSYNC_END        8

// vertical geometry in lines, visible lines first
`define VG_VISIBLE_HEIGHT   8
`define VG_TOTAL_HEIGHT     12
`define VG_VSYNC_START      9
`define VG_VSYNC_END        10

// playfield fetch
`define VG_FETCH_LEAD       4                   // cycles of fetch before first pixel
`define VG_WORDS_PER_LINE   8                   // 4 pixels per word

// register numbers
`define VG_REG_VID_CTRL     6'h00
`define VG_REG_SCANLINE     6'h01
`define VG_REG_VID_LEFT     6'h02
`define VG_REG_VID_RIGHT    6'h03
`define VG_REG_PA_GFX_CTRL  6'h10
`define VG_REG_PA_DISP_ADDR 6'h12
`define VG_REG_PA_LINE_LEN  6'h13

`define VG_BORDER_RESET     8'h08               // dark grey

`endif

// File: hdl/video_gen_pkg.sv
// Shared types of the video generator; imported by the RTL modules and interfaces
`default_nettype none

package video_gen_pkg;

    typedef logic [15:0] word_t;                // register and vram data
    typedef logic [15:0] addr_t;                // vram word address
    typedef logic [7:0]  color_t;               // palette index
    typedef logic [5:0]  reg_num_t;             // register number
    typedef logic [5:0]  hres_t;                // pixel counter, also visible column
    typedef logic [3:0]  vres_t;                // line counter

    // cycles from a pixel's h_count to its playfield index
    localparam int PF_LATENCY = 2;

    // playfield configuration as written through the registers
    typedef struct packed {
        logic   blank;                          // show border only, no fetch
        color_t colorbase;                      // XORed into every pixel index
        addr_t  start_addr;                     // first word of line 0
        word_t  line_len;                       // words added per line
    } pf_cfg_t;

endpackage

`default_nettype wire

// File: hdl/video_reg_file.sv
// Video config registers: decodes writes, drives the config bundle, returns registered read data
`default_nettype none
`timescale 1ns/1ps

`include "video_gen_defs.svh"

module video_reg_file (
    input  wire logic                   reg_wr_en_i,    // one cycle write strobe
    input  wire video_gen_pkg::reg_num_t reg_num_i,
    input  wire video_gen_pkg::word_t   reg_data_i,
    output      video_gen_pkg::word_t   reg_data_o,     // reg selected last cycle
    output      logic                   video_intr_o,   // end of visible area pulse
    video_timing_if.sink                tif,
    video_cfg_if.source                 cfg,
    input  wire logic                   reset_i,
    input  wire logic                   clk
);
    import video_gen_pkg::*;

    word_t rd_data;

    // register writes and interrupt
    always_ff @(posedge clk) begin
        if (reset_i) begin
            video_intr_o            <= 1'b0;
            cfg.border_color        <= `VG_BORDER_RESET;
            cfg.vid_left            <= '0;
            cfg.vid_right           <= hres_t'(`VG_VISIBLE_WIDTH);
            cfg.pf_cfg.blank        <= 1'b1;        // playfield starts blanked
            cfg.pf_cfg.colorbase    <= '0;
            cfg.pf_cfg.start_addr   <= '0;
            cfg.pf_cfg.line_len     <= word_t'(`VG_WORDS_PER_LINE);
        end else begin
            video_intr_o <= tif.end_of_visible;

            if (reg_wr_en_i) begin
                case (reg_num_i)
                    `VG_REG_VID_CTRL: begin
                        cfg.border_color <= reg_data_i[7:0];
                    end
                    `VG_REG_VID_LEFT: begin
                        cfg.vid_left <= hres_t'(reg_data_i);
                    end
                    `VG_REG_VID_RIGHT: begin
                        cfg.vid_right <= hres_t'(reg_data_i);
                    end
                    `VG_REG_PA_GFX_CTRL: begin
                        cfg.pf_cfg.colorbase <= reg_data_i[15:8];
                        cfg.pf_cfg.blank     <= reg_data_i[7];
                    end
                    `VG_REG_PA_DISP_ADDR: begin
                        cfg.pf_cfg.start_addr <= reg_data_i;
                    end
                    `VG_REG_PA_LINE_LEN: begin
                        cfg.pf_cfg.line_len <= reg_data_i;
                    end
                    default: begin                  // SCANLINE and unused are read only
                    end
                endcase
            end
        end
    end

    // read mux
    always_comb begin
        rd_data = '0;
        case (reg_num_i)
            `VG_REG_VID_CTRL:     rd_data = {8'h00, cfg.border_color};
            `VG_REG_SCANLINE:     rd_data = word_t'(tif.v_count);
            `VG_REG_VID_LEFT:     rd_data = word_t'(cfg.vid_left);
            `VG_REG_VID_RIGHT:    rd_data = word_t'(cfg.vid_right);
            `VG_REG_PA_GFX_CTRL:  rd_data = {cfg.pf_cfg.colorbase, cfg.pf_cfg.blank, 7'b0};
            `VG_REG_PA_DISP_ADDR: rd_data = cfg.pf_cfg.start_addr;
            `VG_REG_PA_LINE_LEN:  rd_data = cfg.pf_cfg.line_len;
            default:              rd_data = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        reg_data_o <= rd_data;                      // one cycle read latency
    end

    // a write with an unknown register number would corrupt the config
    a_wr_num_known: assert property (
        @(posedge clk) disable iff (reset_i) reg_wr_en_i |-> !$isunknown(reg_num_i)
    ) else $error("register write with unknown register number");

endmodule

`default_nettype wire

// File: hdl/video_timing.sv
// Video timing generator: pixel and line counters with registered sync, visibility and events
`default_nettype none
`timescale 1ns/1ps

`include "video_gen_defs.svh"

module video_timing (
    video_timing_if.source  tif,
    input  wire logic       reset_i,
    input  wire logic       clk
);
    import video_gen_pkg::*;

    localparam hres_t H_LAST     = hres_t'(`VG_TOTAL_WIDTH - 1);
    localparam vres_t V_LAST     = vres_t'(`VG_TOTAL_HEIGHT - 1);
    localparam vres_t V_VIS_LAST = vres_t'(`VG_VISIBLE_HEIGHT - 1);

    hres_t h_next;
    vres_t v_next;

    always_comb begin
        h_next = tif.h_count + 1'b1;
        v_next = tif.v_count;
        if (tif.h_count == H_LAST) begin
            h_next = '0;
            v_next = (tif.v_count == V_LAST) ? vres_t'(0) : tif.v_count + 1'b1;
        end
    end

    // flags are computed from the next count so they line up with it
    always_ff @(posedge clk) begin
        if (reset_i) begin
            tif.h_count        <= '0;
            tif.v_count        <= '0;
            tif.h_visible      <= 1'b0;
            tif.v_visible      <= 1'b1;             // line 0 is visible
            tif.end_of_line    <= 1'b0;
            tif.end_of_frame   <= 1'b0;
            tif.end_of_visible <= 1'b0;
            tif.hsync          <= 1'b0;
            tif.vsync          <= 1'b0;
        end else begin
            tif.h_count        <= h_next;
            tif.v_count        <= v_next;
            tif.h_visible      <= (h_next >= `VG_OFFSCREEN_WIDTH);
            tif.v_visible      <= (v_next < `VG_VISIBLE_HEIGHT);
            tif.end_of_line    <= (h_next == H_LAST);
            tif.end_of_frame   <= (h_next == H_LAST) && (v_next == V_LAST);
            tif.end_of_visible <= (h_next == H_LAST) && (v_next == V_VIS_LAST);
            tif.hsync          <= (h_next >= `VG_HSYNC_START) && (h_next < `VG_HSYNC_END);
            tif.vsync          <= (v_next >= `VG_VSYNC_START) && (v_next < `VG_VSYNC_END);
        end
    end

    a_h_in_range: assert property (
        @(posedge clk) disable iff (reset_i) tif.h_count < `VG_TOTAL_WIDTH
    ) else $error("h_count beyond line length");

endmodule

`default_nettype wire

// File: sources.f
+incdir+hdl
hdl/video_gen_pkg.sv
hdl/video_bus_if.sv
hdl/video_reg_file.sv
hdl/video_timing.sv
hdl/bitmap_playfield.sv
hdl/pixel_out.sv
hdl/video_gen.sv
testbench/video_gen_tb.sv

// File: testbench/video_gen_stim.txt
# W reg data writes data to reg, R reg data reads reg and compares with data, all hex
# F n checks the next n whole frames; a SCANLINE read only checks it is below the frame height
R 00 0008
R 01 0000
R 02 0000
R 03 0020
R 10 0080
R 12 0000
R 13 0008
R 05 0000
F 1
W 00 1233
R 00 0033
W 02 ffc4
R 02 0004
W 03 001c
R 03 001c
W 12 1234
W 13 000a
R 12 1234
R 13 000a
W 10 a57f
R 10 a500
F 2
W 12 fff8
W 13 0020
F 1

// File: testbench/video_gen_tb.sv
// Self-checking testbench for the video generator; runs the command list in the stim file
`default_nettype none
`timescale 1ns/1ps

`include "video_gen_defs.svh"

module video_gen_tb;
    localparam int FRAME_CYCLES = `VG_TOTAL_WIDTH * `VG_TOTAL_HEIGHT;
    localparam int DE_PER_FRAME = `VG_VISIBLE_WIDTH * `VG_VISIBLE_HEIGHT;
    localparam int HS_PER_FRAME = (`VG_HSYNC_END - `VG_HSYNC_START) * `VG_TOTAL_HEIGHT;
    localparam int HVIS_PER_FRAME = `VG_VISIBLE_WIDTH * `VG_TOTAL_HEIGHT;
    localparam int VVIS_PER_FRAME = `VG_TOTAL_WIDTH * `VG_VISIBLE_HEIGHT;

    logic        clk;
    logic        reset_i;
    logic        reg_wr_en_i;
    logic [5:0]  reg_num_i;
    logic [15:0] reg_data_i;
    logic [15:0] reg_data_o;
    logic        video_intr_o;
    logic        vram_sel_o;
    logic [15:0] vram_addr_o;
    logic [15:0] vram_data_i;
    logic [7:0]  color_index_o;
    logic        h_blank_o;
    logic        v_blank_o;
    logic        hsync_o;
    logic        vsync_o;
    logic        dv_de_o;

    logic [15:0] vram [0:65535];                    // whole word address space
    logic        req_pending;
    logic [15:0] req_addr;

    logic [7:0]  m_border;                          // mirror of the written registers
    logic        m_blank;
    logic [7:0]  m_colorbase;
    logic [5:0]  m_left;
    logic [5:0]  m_right;
    logic [15:0] m_start;
    logic [15:0] m_len;

    int          cmd_q[$];                          // 0 write, 1 read, 2 frame check
    logic [15:0] arg_a_q[$];
    logic [15:0] arg_b_q[$];
    int          n_checks = 0;
    int          n_errors = 0;
    int          frame_no = 0;
    int          cycle_limit = 0;
    logic        limit_ready = 1'b0;

    video_gen dut (
        .reg_wr_en_i(reg_wr_en_i), .reg_num_i(reg_num_i),
        .reg_data_i(reg_data_i), .reg_data_o(reg_data_o), .video_intr_o(video_intr_o),
        .vram_sel_o(vram_sel_o), .vram_addr_o(vram_addr_o), .vram_data_i(vram_data_i),
        .color_index_o(color_index_o), .h_blank_o(h_blank_o), .v_blank_o(v_blank_o),
        .hsync_o(hsync_o), .vsync_o(vsync_o), .dv_de_o(dv_de_o),
        .reset_i(reset_i), .clk(clk)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_value(input string name, input logic [15:0] exp, input logic [15:0] act);
        n_checks++;
        assert (act === exp) else begin
            n_errors++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    // memory answers the address seen with the select one cycle later
    always @(negedge clk) begin
        req_pending = vram_sel_o;
        req_addr    = vram_addr_o;
        if (!reset_i) begin
            assert (!(m_blank && vram_sel_o)) else begin
                n_errors++;
                $display("VRAM select seen while the playfield is blanked at %0t", $time);
            end
        end
    end

    always @(posedge clk) begin
        #2;
        if (req_pending) begin
            vram_data_i = vram[req_addr];
        end
    end

    task automatic parse_stim();
        int               fd;
        int               code;
        int               n_frames;
        int               n_regs;
        logic [8*8-1:0]   tok;
        logic [8*128-1:0] rest;
        logic [15:0]      a;
        logic [15:0]      b;
        n_frames = 0;
        n_regs   = 0;
        fd = $fopen("testbench/video_gen_stim.txt", "r");
        if (fd == 0) begin
            n_errors++;
            $display("could not open the stim file testbench/video_gen_stim.txt");
        end else begin
            while ($fscanf(fd, "%s", tok) == 1) begin
                if (tok == "#") begin
                    code = $fgets(rest, fd);        // rest of a comment line
                end else if (tok == "W" || tok == "R") begin
                    code = $fscanf(fd, "%h %h", a, b);
                    cmd_q.push_back((tok == "W") ? 0 : 1);
                    arg_a_q.push_back(a);
                    arg_b_q.push_back(b);
                    n_regs++;
                end else if (tok == "F") begin
                    code = $fscanf(fd, "%d", a);
                    cmd_q.push_back(2);
                    arg_a_q.push_back(a);
                    arg_b_q.push_back(16'h0);
                    n_frames += a + 1;              // up to one frame to find the frame start
                end else begin
                    n_errors++;
                    $display("unknown command in the stim file");
                end
            end
            $fclose(fd);
        end
        cycle_limit = n_frames * FRAME_CYCLES + 4 * n_regs + 200 + 5;
    endtask

    task automatic write_reg(input logic [5:0] num, input logic [15:0] data);
        @(posedge clk);
        #2;
        reg_wr_en_i = 1'b1;
        reg_num_i   = num;
        reg_data_i  = data;
        @(posedge clk);
        #2;
        reg_wr_en_i = 1'b0;
        case (num)                                  // mirror follows the field layout
            `VG_REG_VID_CTRL:     m_border = data[7:0];
            `VG_REG_VID_LEFT:     m_left = data[5:0];
            `VG_REG_VID_RIGHT:    m_right = data[5:0];
            `VG_REG_PA_GFX_CTRL:  {m_colorbase, m_blank} = data[15:7];
            `VG_REG_PA_DISP_ADDR: m_start = data;
            `VG_REG_PA_LINE_LEN:  m_len = data;
            default:              ;
        endcase
    endtask

    task automatic read_reg(input logic [5:0] num, input logic [15:0] exp);
        @(posedge clk);
        #2;
        reg_num_i = num;
        @(posedge clk);                             // read data registered here
        @(negedge clk);
        if (num == `VG_REG_SCANLINE) begin
            n_checks++;
            assert (reg_data_o < `VG_TOTAL_HEIGHT) else begin
                n_errors++;
                $display("CHECK FAILED read SCANLINE: expected below %h, actual %h",
                         16'(`VG_TOTAL_HEIGHT), reg_data_o);
            end
        end else begin
            check_value($sformatf("read reg %h", num), exp, reg_data_o);
        end
    endtask

    function automatic logic [7:0] expected_pixel(input int line, input int col);
        logic [15:0] addr;
        logic [15:0] data;
        logic [3:0]  nib;
        if (m_blank || col < m_left || col >= m_right) begin
            return m_border;
        end
        addr = 16'(m_start + line * m_len + col / 4);
        data = vram[addr];
        nib  = 4'(data >> (4 * (3 - col % 4)));     // leftmost pixel in the top nibble
        return {4'h0, nib} ^ m_colorbase;
    endfunction

    // one frame window runs from the end of one vsync pulse to the end of the next
    task automatic check_frame();
        int   de_count;
        int   vs_cycles;
        int   vs_pulses;
        int   intr_cycles;
        int   hs_cycles;
        int   hvis_cycles;
        int   vvis_cycles;
        int   de_mismatch;
        logic vs_prev;
        de_count    = 0;
        vs_cycles   = 0;
        vs_pulses   = 0;
        intr_cycles = 0;
        hs_cycles   = 0;
        hvis_cycles = 0;
        vvis_cycles = 0;
        de_mismatch = 0;
        vs_prev     = 1'b0;
        for (int i = 0; i < FRAME_CYCLES; i++) begin
            if (i > 0) begin
                @(negedge clk);
            end
            if (dv_de_o) begin
                check_value($sformatf("frame %0d pixel %0d", frame_no, de_count),
                            expected_pixel(de_count / `VG_VISIBLE_WIDTH,
                                           de_count % `VG_VISIBLE_WIDTH), color_index_o);
                de_count++;
            end
            vs_cycles   += vsync_o;
            vs_pulses   += (vsync_o && !vs_prev);
            intr_cycles += video_intr_o;
            hs_cycles   += hsync_o;
            hvis_cycles += !h_blank_o;
            vvis_cycles += !v_blank_o;
            de_mismatch += (dv_de_o != (!h_blank_o && !v_blank_o));   // enable only when both unblanked
            vs_prev      = vsync_o;
        end
        check_value($sformatf("frame %0d de cycles", frame_no), DE_PER_FRAME, de_count);
        check_value($sformatf("frame %0d vsync cycles", frame_no), `VG_TOTAL_WIDTH, vs_cycles);
        check_value($sformatf("frame %0d vsync pulses", frame_no), 1, vs_pulses);
        check_value($sformatf("frame %0d intr cycles", frame_no), 1, intr_cycles);
        check_value($sformatf("frame %0d hsync cycles", frame_no), HS_PER_FRAME, hs_cycles);
        check_value($sformatf("frame %0d h unblanked cycles", frame_no), HVIS_PER_FRAME,
                    hvis_cycles);
        check_value($sformatf("frame %0d v unblanked cycles", frame_no), VVIS_PER_FRAME,
                    vvis_cycles);
        check_value($sformatf("frame %0d de vs blank mismatches", frame_no), 0, de_mismatch);
        frame_no++;
    endtask

    task automatic run_frames(input int count);
        @(negedge clk);
        while (!vsync_o) @(negedge clk);
        while (vsync_o) @(negedge clk);            // first cycle after the pulse
        for (int f = 0; f < count; f++) begin
            if (f > 0) begin
                @(negedge clk);
            end
            check_frame();
        end
    endtask

    initial begin
        logic [31:0] state;
        reset_i     = 1'b1;
        reg_wr_en_i = 1'b0;
        reg_num_i   = '0;
        reg_data_i  = '0;
        vram_data_i = '0;
        m_border    = `VG_BORDER_RESET;
        m_blank     = 1'b1;
        m_colorbase = '0;
        m_left      = '0;
        m_right     = `VG_VISIBLE_WIDTH;
        m_start     = '0;
        m_len       = `VG_WORDS_PER_LINE;
        state       = 32'h5982;
        for (int i = 0; i < 65536; i++) begin
            state   = lcg_next(state);
            vram[i] = state[31:16];
        end
        parse_stim();
        limit_ready = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        check_value("reset vram_sel", 0, vram_sel_o);
        check_value("reset intr", 0, video_intr_o);
        check_value("reset de", 0, dv_de_o);
        check_value("reset hsync", 0, hsync_o);
        check_value("reset vsync", 0, vsync_o);
        @(posedge clk);
        #2;
        reset_i = 1'b0;
        for (int i = 0; i < cmd_q.size(); i++) begin
            case (cmd_q[i])
                0:       write_reg(arg_a_q[i][5:0], arg_b_q[i]);
                1:       read_reg(arg_a_q[i][5:0], arg_b_q[i]);
                default: run_frames(arg_a_q[i]);
            endcase
        end
        repeat (4) @(posedge clk);
        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // run limit from the command list
    initial begin
        int cycle_count;
        cycle_count = 0;
        wait (limit_ready);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: the run did not end within %0d cycles", cycle_limit);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire
